//--- Bender.yml
package:
  name: adc_spi_master

sources:
  - files:
      - spi_frame_pkg.sv
      - adc_cmd_pkg.sv
      - adc_spi_sequencer.sv
      - adc_cmd_table.sv
      - spi_shift_engine.sv
      - adc_spi_master.sv
  - target: test
    files:
      - adc_spi_slave_model.sv
      - adc_spi_master_tb.sv

//--- adc_cmd_pkg.sv
/*
  ADC bring-up command set and the two response codes that steer it.
  Only the upper 16 bits of a response are ever compared.
  The table order matters: index 2 to 8 is the configuration run.
*/
`default_nettype none

package adc_cmd_pkg;

	typedef logic [3:0] cmd_index_t;  // index into CMD_WORDS

	localparam int CMD_COUNT = 9;

	localparam logic [15:0] RESP_ID    = 16'hff04;  // device id reply, go to cmd 1
	localparam logic [15:0] RESP_SETUP = 16'h0655;  // setup ack, start config run

	// upper halves of the frames, sent in this order
	localparam logic [15:0] CMD_WORDS [CMD_COUNT] = '{
		16'h0000,  // 0 read id
		16'h0655,  // 1 setup
		16'h4b68,
		16'h4c3e,
		16'h4d02,
		16'h4e25,
		16'h4f0f,
		16'h0033,
		16'h0555   // 8 last one, next is cmd 0
	};

endpackage

`default_nettype wire

//--- adc_cmd_table.sv
/*
  Command index and its stepping rule. The index moves only on
  result.done and is steered by the upper half of the captured word.
  tx_word is stable between frames, so the engine may load it any time.
*/
`timescale 1ns/1ps
`default_nettype none

module adc_cmd_table (
	input  logic                         SPI_SCLK_internal_use,
	input  logic                         reset_n,
	input  spi_frame_pkg::frame_result_t result,
	output spi_frame_pkg::frame_word_t   tx_word
);
	import adc_cmd_pkg::*;

	localparam cmd_index_t RUN_FIRST = cmd_index_t'(2);
	localparam cmd_index_t RUN_LAST  = cmd_index_t'(CMD_COUNT - 1);

	cmd_index_t idx;
	cmd_index_t idx_next;

	// response decode, id and setup replies win over stepping
	always_comb
	begin
		if (result.rx.cmd == RESP_ID)
			idx_next = cmd_index_t'(1);
		else if (result.rx.cmd == RESP_SETUP)
			idx_next = RUN_FIRST;
		else if (idx >= RUN_FIRST && idx < RUN_LAST)
			idx_next = idx + 1'b1;  // walk the config run
		else
			idx_next = '0;  // after last cmd or a neutral reply
	end

	always_ff @(posedge SPI_SCLK_internal_use or negedge reset_n)
	begin
		if (!reset_n)
			idx <= '0;
		else if (result.done)
			idx <= idx_next;
	end

	assign tx_word = '{cmd: CMD_WORDS[idx], data: '0};

endmodule

`default_nettype wire

//--- adc_spi_master.f
spi_frame_pkg.sv
adc_cmd_pkg.sv
adc_spi_sequencer.sv
adc_cmd_table.sv
spi_shift_engine.sv
adc_spi_master.sv
adc_spi_slave_model.sv
adc_spi_master_tb.sv

//--- adc_spi_master.sv
/*
  SPI master for ADC bring-up. Everything runs on SPI_SCLK_internal_use;
  sclk is divided down by 2*SCLK_HALF. Mode 0 only.
  One frame per trigger, no handshake: trigger is a plain level.
*/
`timescale 1ns/1ps
`default_nettype none

module adc_spi_master #(
	parameter int SCLK_HALF    = 3,   // clocks per sclk half period
	parameter int RESET_CYCLES = 20   // adc reset pulse length
) (
	input  logic SPI_SCLK_internal_use,
	input  logic reset_n,
	input  logic trigger,
	input  logic miso,
	output logic sclk,
	output logic mosi,
	output logic cs_n,
	output logic adc_reset_n
);
	import spi_frame_pkg::*;

	logic          frame_start;
	frame_word_t   tx_word;
	frame_result_t result;

	adc_spi_sequencer #(
		.RESET_CYCLES(RESET_CYCLES)
	) sequencer_inst (
		.SPI_SCLK_internal_use(SPI_SCLK_internal_use),
		.reset_n              (reset_n),
		.trigger              (trigger),
		.result               (result),
		.frame_start          (frame_start),
		.cs_n                 (cs_n),
		.adc_reset_n          (adc_reset_n)
	);

	adc_cmd_table cmd_table_inst (
		.SPI_SCLK_internal_use(SPI_SCLK_internal_use),
		.reset_n              (reset_n),
		.result               (result),
		.tx_word              (tx_word)
	);

	spi_shift_engine #(
		.SCLK_HALF(SCLK_HALF)
	) shift_engine_inst (
		.SPI_SCLK_internal_use(SPI_SCLK_internal_use),
		.reset_n              (reset_n),
		.frame_start          (frame_start),
		.tx_word              (tx_word),
		.miso                 (miso),
		.sclk                 (sclk),
		.mosi                 (mosi),
		.result               (result)
	);

endmodule

`default_nettype wire

//--- adc_spi_master_tb.sv
/*
  Testbench for adc_spi_master with a mode 0 ADC model on the bus.
  Neutral MISO replies come from a 32-bit LFSR with a fixed seed.
  The run stops by itself at a cycle limit.
*/
`timescale 1ns/1ps
`default_nettype none

module adc_spi_master_tb;
	import spi_frame_pkg::*;

	localparam int SCLK_HALF    = 3;
	localparam int RESET_CYCLES = 20;
	localparam int IDLE_CYCLES  = 200;
	localparam int N_STIM       = 13;
	localparam int TIMEOUT      = N_STIM * (64 * SCLK_HALF + 8) + RESET_CYCLES
		+ IDLE_CYCLES + 50;

	typedef struct packed {
		logic        neutral;  // reply drawn from the lfsr
		logic [15:0] resp;     // reply upper half otherwise
		logic [15:0] exp_cmd;  // command expected on mosi
	} stim_t;

	localparam stim_t STIM_TAB [N_STIM] = '{
		'{1'b1, 16'h0000, 16'h0000},  // first frame, neutral reply keeps cmd 0
		'{1'b0, 16'hff04, 16'h0000},
		'{1'b1, 16'h0000, 16'h0655},  // neutral after cmd 1 goes back to 0
		'{1'b0, 16'hff04, 16'h0000},
		'{1'b0, 16'h0655, 16'h0655},  // setup ack starts the config run
		'{1'b1, 16'h0000, 16'h4b68},
		'{1'b1, 16'h0000, 16'h4c3e},
		'{1'b1, 16'h0000, 16'h4d02},
		'{1'b1, 16'h0000, 16'h4e25},
		'{1'b1, 16'h0000, 16'h4f0f},
		'{1'b1, 16'h0000, 16'h0033},
		'{1'b1, 16'h0000, 16'h0555},
		'{1'b1, 16'h0000, 16'h0000}   // wrapped after the last command
	};

	logic        SPI_SCLK_internal_use;
	logic        reset_n;
	logic        trigger;
	logic        miso;
	logic        sclk;
	logic        mosi;
	logic        cs_n;
	logic        adc_reset_n;
	frame_word_t resp_word;
	frame_word_t rx_word;
	logic [7:0]  rise_count;
	logic [31:0] lfsr;
	int          cycle_cnt = 0;
	int          tests_run;
	int          tests_failed;
	int          errors;

	initial
		SPI_SCLK_internal_use = 1'b0;

	always #4 SPI_SCLK_internal_use = ~SPI_SCLK_internal_use;

	adc_spi_master #(
		.SCLK_HALF   (SCLK_HALF),
		.RESET_CYCLES(RESET_CYCLES)
	) adc_spi_master_inst (
		.SPI_SCLK_internal_use(SPI_SCLK_internal_use),
		.reset_n              (reset_n),
		.trigger              (trigger),
		.miso                 (miso),
		.sclk                 (sclk),
		.mosi                 (mosi),
		.cs_n                 (cs_n),
		.adc_reset_n          (adc_reset_n)
	);

	adc_spi_slave_model slave_model_inst (
		.sclk      (sclk),
		.cs_n      (cs_n),
		.mosi      (mosi),
		.resp_word (resp_word),
		.miso      (miso),
		.rx_word   (rx_word),
		.rise_count(rise_count)
	);

	// taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic draw_neutral(output frame_word_t w);
		logic [31:0] bits;
		do
		begin
			for (int b = 0; b < 32; b++)
			begin
				lfsr = lfsr_next(lfsr);
				bits = {bits[30:0], lfsr[0]};
			end
		end while (bits[31:16] == 16'hff04 || bits[31:16] == 16'h0655);
		w = bits;
	endtask

	task automatic load_reply(input stim_t s);
		if (s.neutral)
			draw_neutral(resp_word);
		else
			resp_word = {s.resp, 16'h0000};
	endtask

	task automatic wait_cs(input logic level);
		do
			@(negedge SPI_SCLK_internal_use);
		while (cs_n !== level);
	endtask

	task automatic check(input logic ok, input string msg);
		assert (ok)
		else
		begin
			$display("[FAIL] t=%0t %s", $time, msg);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int fail_before);
		tests_run++;
		if (errors > fail_before)
		begin
			tests_failed++;
			$display("test %0d %s: FAIL", tests_run, name);
		end
		else
			$display("test %0d %s: ok", tests_run, name);
	endtask

	initial
	begin
		int          fail_before;
		int          low_cycles;
		frame_word_t exp_word;
		reset_n      = 1'b0;
		trigger      = 1'b1;  // held high through the adc reset pulse
		lfsr         = 32'hf119;
		errors       = 0;
		tests_run    = 0;
		tests_failed = 0;
		load_reply(STIM_TAB[0]);
		repeat (5) @(posedge SPI_SCLK_internal_use);
		#1 reset_n = 1'b1;

		fail_before = errors;
		low_cycles  = 0;
		@(negedge SPI_SCLK_internal_use);
		while (adc_reset_n !== 1'b1)
		begin
			check(cs_n === 1'b1, "cs_n went low during the adc reset pulse");
			low_cycles++;
			@(negedge SPI_SCLK_internal_use);
		end
		check(low_cycles == RESET_CYCLES, $sformatf("adc reset pulse %0d clocks, expected %0d",
			low_cycles, RESET_CYCLES));
		report_test("adc reset pulse", fail_before);

		for (int i = 0; i < N_STIM; i++)
		begin
			fail_before = errors;
			exp_word    = {STIM_TAB[i].exp_cmd, 16'h0000};
			if (i > 0)
			begin
				@(posedge SPI_SCLK_internal_use);
				#1;
				load_reply(STIM_TAB[i]);
				trigger = 1'b1;
			end
			wait_cs(1'b0);
			wait_cs(1'b1);
			@(posedge SPI_SCLK_internal_use);
			#1 trigger = 1'b0;
			check(rx_word === exp_word, $sformatf("frame %0d sent %h, expected %h",
				i, rx_word, exp_word));
			check(rise_count == 8'd32, $sformatf("frame %0d had %0d sclk rises, expected 32",
				i, rise_count));
			check(mosi === 1'b1, "mosi not back at idle high after the frame");
			report_test($sformatf("frame %0d cmd %h", i, exp_word.cmd), fail_before);
		end

		fail_before = errors;
		repeat (IDLE_CYCLES)
		begin
			@(negedge SPI_SCLK_internal_use);
			check(cs_n === 1'b1 && sclk === 1'b0, "bus active while trigger is low");
		end
		report_test("idle with trigger low", fail_before);

		$display("tests run %0d, tests failed %0d, failed checks %0d",
			tests_run, tests_failed, errors);
		if (errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

	always @(posedge SPI_SCLK_internal_use)
	begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT)
		begin
			$display("run timed out after %0d clocks, a frame never completed", cycle_cnt);
			$display("Verification failed");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- adc_spi_sequencer.sv
/*
  Holds adc_reset_n low for RESET_CYCLES clocks after reset, then frames
  one transaction per trigger. Triggers during the reset pulse or a frame
  are dropped. cs_n stays high at least two clocks between frames.
*/
`timescale 1ns/1ps
`default_nettype none

module adc_spi_sequencer #(
	parameter int RESET_CYCLES = 20
) (
	input  logic                         SPI_SCLK_internal_use,
	input  logic                         reset_n,
	input  logic                         trigger,
	input  spi_frame_pkg::frame_result_t result,
	output logic                         frame_start,
	output logic                         cs_n,
	output logic                         adc_reset_n
);
	localparam int CNT_W = $clog2(RESET_CYCLES + 1);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(RESET_CYCLES - 1);

	typedef enum logic [2:0] {
		ST_RST_PULSE,  // adc held in reset
		ST_WAIT,       // idle, looking for trigger
		ST_SETUP,      // cs_n low, one clock before sclk starts
		ST_BUSY,       // shift engine running
		ST_END         // cs_n back high
	} seq_state_t;

	seq_state_t       state;
	logic [CNT_W-1:0] rst_cnt;

	always_ff @(posedge SPI_SCLK_internal_use or negedge reset_n)
	begin
		if (!reset_n)
		begin
			state       <= ST_RST_PULSE;
			rst_cnt     <= '0;
			frame_start <= 1'b0;
			cs_n        <= 1'b1;
			adc_reset_n <= 1'b0;  // pulse starts right at reset release
		end
		else
		begin
			frame_start <= 1'b0;
			case (state)
				ST_RST_PULSE:
				begin
					if (rst_cnt == CNT_LAST)
					begin
						adc_reset_n <= 1'b1;
						state       <= ST_WAIT;
					end
					else
						rst_cnt <= rst_cnt + 1'b1;
				end
				ST_WAIT:
				begin
					if (trigger)
					begin
						cs_n  <= 1'b0;
						state <= ST_SETUP;
					end
				end
				ST_SETUP:
				begin
					frame_start <= 1'b1;  // cs setup time is this one clock
					state       <= ST_BUSY;
				end
				ST_BUSY:
				begin
					if (result.done)
					begin
						cs_n  <= 1'b1;
						state <= ST_END;
					end
				end
				ST_END:
					state <= ST_WAIT;  // guarantees cs_n high gap
				default:
					state <= ST_WAIT;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- adc_spi_slave_model.sv
/*
  ADC stand-in for the testbench, SPI mode 0 only.
  resp_word must be set while cs_n is high, it is loaded as cs_n falls.
  rx_word and rise_count hold the last frame until cs_n falls again.
*/
`timescale 1ns/1ps
`default_nettype none

module adc_spi_slave_model (
	input  logic                       sclk,
	input  logic                       cs_n,
	input  logic                       mosi,
	input  spi_frame_pkg::frame_word_t resp_word,
	output logic                       miso,
	output spi_frame_pkg::frame_word_t rx_word,
	output logic [7:0]                 rise_count
);
	import spi_frame_pkg::*;

	logic [FRAME_BITS-1:0] tx_shift = '0;
	logic [FRAME_BITS-1:0] rx_shift = '0;
	logic                  miso_q   = 1'b1;  // idle high
	logic [7:0]            rises    = '0;

	assign miso       = miso_q;
	assign rx_word    = rx_shift;
	assign rise_count = rises;

	// one pass per frame, ends when cs_n rises
	always @(negedge cs_n)
	begin
		tx_shift = resp_word;
		rx_shift = '0;
		rises    = '0;
		miso_q   = tx_shift[FRAME_BITS-1];  // msb ready before the first rise
		while (!cs_n)
		begin
			@(posedge sclk or posedge cs_n);
			if (!cs_n)
			begin
				rx_shift = {rx_shift[FRAME_BITS-2:0], mosi};
				rises    = rises + 1'b1;
				@(negedge sclk or posedge cs_n);
				if (!cs_n)
				begin
					tx_shift = {tx_shift[FRAME_BITS-2:0], 1'b0};
					miso_q   = tx_shift[FRAME_BITS-1];  // next bit on the falling edge
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- spi_frame_pkg.sv
/*
  Frame format shared by the SPI shift engine and the blocks around it.
  A frame is 32 bits, MSB first. The upper half carries the command and
  the lower half carries data, which is zero for every command sent here.
*/
`default_nettype none

package spi_frame_pkg;

	localparam int FRAME_BITS = 32;              // bits per SPI frame
	localparam int HALF_BITS  = FRAME_BITS / 2;  // command half, data half

	// one full frame as it travels on MOSI or MISO
	typedef struct packed {
		logic [HALF_BITS-1:0] cmd;   // upper half, sent first
		logic [HALF_BITS-1:0] data;  // lower half
	} frame_word_t;

	// what the shift engine hands back at the end of a frame
	typedef struct packed {
		logic        done;  // one clock, end of frame
		frame_word_t rx;    // word captured from MISO, valid with done
	} frame_result_t;

endpackage

`default_nettype wire

//--- spi_shift_engine.sv
/*
  Mode 0 shift engine: sclk idles low, miso sampled on the rising edge,
  mosi changes on the falling edge. A frame lasts 64*SCLK_HALF clocks
  from frame_start. frame_start is ignored while a frame runs.
*/
`timescale 1ns/1ps
`default_nettype none

module spi_shift_engine #(
	parameter int SCLK_HALF = 3
) (
	input  logic                         SPI_SCLK_internal_use,
	input  logic                         reset_n,
	input  logic                         frame_start,
	input  spi_frame_pkg::frame_word_t   tx_word,
	input  logic                         miso,
	output logic                         sclk,
	output logic                         mosi,
	output spi_frame_pkg::frame_result_t result
);
	import spi_frame_pkg::*;

	localparam int HALF_W  = $clog2(SCLK_HALF + 1);
	localparam int PHASE_W = $clog2(2 * FRAME_BITS);
	localparam logic [HALF_W-1:0]  HALF_LAST  = HALF_W'(SCLK_HALF - 1);
	localparam logic [PHASE_W-1:0] PHASE_LAST = PHASE_W'(2 * FRAME_BITS - 1);

	logic                  busy;
	logic [HALF_W-1:0]     half_cnt;   // clocks within an sclk half
	logic [PHASE_W-1:0]    phase_cnt;  // even: low half, odd: high half
	logic                  half_tick;
	logic                  load;
	logic                  done_q;
	logic [FRAME_BITS-1:0] tx_shift;
	logic [FRAME_BITS-1:0] rx_shift;
	frame_word_t           rx_word;

	assign half_tick = busy && (half_cnt == HALF_LAST);
	assign load      = frame_start && !busy;

	always_ff @(posedge SPI_SCLK_internal_use or negedge reset_n)
	begin
		if (!reset_n)
		begin
			busy      <= 1'b0;
			half_cnt  <= '0;
			phase_cnt <= '0;
			sclk      <= 1'b0;
			mosi      <= 1'b1;
			done_q    <= 1'b0;
		end
		else
		begin
			done_q <= 1'b0;
			if (load)
			begin
				busy      <= 1'b1;
				half_cnt  <= '0;
				phase_cnt <= '0;
				mosi      <= tx_word[FRAME_BITS-1];  // msb out before first rise
			end
			else if (half_tick)
			begin
				half_cnt  <= '0;
				phase_cnt <= phase_cnt + 1'b1;
				if (!phase_cnt[0])
					sclk <= 1'b1;  // rising edge
				else if (phase_cnt == PHASE_LAST)
				begin
					sclk   <= 1'b0;
					mosi   <= 1'b1;  // back to idle level
					busy   <= 1'b0;
					done_q <= 1'b1;
				end
				else
				begin
					sclk <= 1'b0;
					mosi <= tx_shift[FRAME_BITS-2];  // next bit on falling edge
				end
			end
			else if (busy)
				half_cnt <= half_cnt + 1'b1;
		end
	end

	// data path, only meaningful while busy
	always_ff @(posedge SPI_SCLK_internal_use)
	begin
		if (load)
			tx_shift <= tx_word;
		else if (half_tick && !phase_cnt[0])
			rx_shift <= {rx_shift[FRAME_BITS-2:0], miso};
		else if (half_tick && phase_cnt != PHASE_LAST)
			tx_shift <= {tx_shift[FRAME_BITS-2:0], 1'b0};
		if (half_tick && phase_cnt == PHASE_LAST)
			rx_word <= rx_shift;  // all 32 bits in by the last rise
	end

	assign result = '{done: done_q, rx: rx_word};

endmodule

`default_nettype wire
